/* packet_queue_manager.f */
+incdir+hdl
hdl/pqm_pkg.sv
hdl/simple_dp_ram.sv
hdl/rx_handler.sv
hdl/descriptor_queues.sv
hdl/rr_scheduler.sv
hdl/tx_handler.sv
hdl/packet_counter.sv
hdl/packet_queue_manager.sv
testbench/tb_packet_queue_manager.sv

/* Bender.yml */
package:
  name: packet_queue_manager

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pqm_pkg.sv
      - hdl/simple_dp_ram.sv
      - hdl/rx_handler.sv
      - hdl/descriptor_queues.sv
      - hdl/rr_scheduler.sv
      - hdl/tx_handler.sv
      - hdl/packet_counter.sv
      - hdl/packet_queue_manager.sv
      - target: test
        files:
          - testbench/tb_packet_queue_manager.sv

/* testbench/tb_packet_queue_manager.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pqm_config.svh"

module tb_packet_queue_manager;

  import pqm_pkg::*;

  localparam int NQ     = `PQM_NUM_QUEUES;
  localparam int DEPTH  = `PQM_QUEUE_DEPTH;
  localparam int MAXB   = `PQM_MAX_BEATS;
  localparam int RING   = 8;                   // Model entries per queue
  localparam int RR_LEN = 16;
  localparam int N_RAND = 40;

  logic      clk;
  logic      arst_n;
  data_t     s_axis_tdata;
  keep_t     s_axis_tkeep;
  logic      s_axis_tvalid;
  logic      s_axis_tlast;
  logic      s_axis_tready;
  data_t     m_axis_tdata;
  keep_t     m_axis_tkeep;
  logic      m_axis_tvalid;
  logic      m_axis_tready;
  logic      m_axis_tlast;
  logic      reg_rd;
  reg_addr_t reg_addr;
  logic      reg_ack;
  cnt_t      reg_data;

  // Reference model, one ring of expected packets per queue
  int    seq_m    [NQ][RING];
  int    len_m    [NQ][RING];
  keep_t keep_m   [NQ][RING];
  int    wr_ptr   [NQ];
  int    rd_ptr   [NQ];
  int    sent_cnt [NQ];                        // Accepted packets per queue
  int    done_cnt [NQ];                        // Packets seen leaving egress
  int    exp_drops;
  int    pkt_seq;
  cnt_t  exp_reg;

  int    rr_exp [RR_LEN];                      // Expected queue of each packet start
  int    rr_wr;
  int    rr_rd;

  // Egress monitor
  logic  in_pkt;
  qid_t  pkt_q;
  int    beat_idx;
  logic  serving;                              // A beat is waiting at egress
  qid_t  serving_q;

  logic  xfer;
  qid_t  cur_q;
  int    head;
  logic  exp_avail;
  data_t exp_data;
  keep_t exp_keep;
  logic  exp_last;
  logic  rr_ok;
  logic  rand_busy;

  packet_queue_manager i_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .s_axis_tdata_i  (s_axis_tdata),
    .s_axis_tkeep_i  (s_axis_tkeep),
    .s_axis_tvalid_i (s_axis_tvalid),
    .s_axis_tlast_i  (s_axis_tlast),
    .s_axis_tready_o (s_axis_tready),
    .m_axis_tdata_o  (m_axis_tdata),
    .m_axis_tkeep_o  (m_axis_tkeep),
    .m_axis_tvalid_o (m_axis_tvalid),
    .m_axis_tready_i (m_axis_tready),
    .m_axis_tlast_o  (m_axis_tlast),
    .reg_rd_i        (reg_rd),
    .reg_addr_i      (reg_addr),
    .reg_ack_o       (reg_ack),
    .reg_data_o      (reg_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("** Error [%0t] %s", $time, msg);
    end_with_failure();
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    end_with_failure();
  endtask

  // Queue id in the top byte, sequence and beat index below
  function automatic data_t beat_data(input int q, input int seq, input int idx);
    return {8'hA0 | 8'(q), 16'(seq), 8'(idx), 32'h5EED_0000 ^ {16'(seq), 8'(idx), 8'(q)}};
  endfunction

  // Packets held in the descriptor queue, the one at egress excluded
  function automatic int waiting(input int q);
    return sent_cnt[q] - done_cnt[q] - ((serving && serving_q == q) ? 1 : 0);
  endfunction

  function automatic logic drained();
    logic empty;
    int   q;
    empty = !serving;
    for (q = 0; q < NQ; q++) begin
      if (sent_cnt[q] != done_cnt[q]) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  function automatic int expected_reg(input int addr);
    if (addr < NQ) begin
      return sent_cnt[addr];
    end else if (addr == NQ) begin
      return exp_drops;
    end
    return 0;
  endfunction

  always_comb begin
    xfer      = m_axis_tvalid && m_axis_tready;
    cur_q     = in_pkt ? pkt_q : qid_t'(m_axis_tdata[57:56]);
    head      = rd_ptr[cur_q] % RING;
    exp_avail = wr_ptr[cur_q] != rd_ptr[cur_q];
    exp_last  = beat_idx == len_m[cur_q][head] - 1;
    exp_data  = beat_data(cur_q, seq_m[cur_q][head], beat_idx);
    exp_keep  = exp_last ? keep_m[cur_q][head] : '1;
    rr_ok     = (rr_rd == rr_wr) || (rr_exp[rr_rd % RR_LEN] == int'(cur_q));
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int q = 0; q < NQ; q++) begin
        rd_ptr[q]   <= 0;
        done_cnt[q] <= 0;
      end
      in_pkt    <= 1'b0;
      pkt_q     <= '0;
      beat_idx  <= 0;
      rr_rd     <= 0;
      serving   <= 1'b0;
      serving_q <= '0;
    end else begin
      if (xfer) begin
        pkt_q <= cur_q;
        if (!in_pkt && (rr_rd != rr_wr)) begin
          rr_rd <= rr_rd + 1;
        end
        if (m_axis_tlast) begin
          in_pkt        <= 1'b0;
          beat_idx      <= 0;
          rd_ptr[cur_q] <= rd_ptr[cur_q] + 1;  // Packet retired from the model
          done_cnt[cur_q] <= done_cnt[cur_q] + 1;
        end else begin
          in_pkt   <= 1'b1;
          beat_idx <= beat_idx + 1;
        end
      end
      serving   <= m_axis_tvalid && !(xfer && m_axis_tlast);
      serving_q <= cur_q;
    end
  end

  a_ready_high: assert property (@(posedge clk) disable iff (!arst_n) s_axis_tready)
    else report_mismatch("ingress tready went low");

  a_known_packet: assert property (@(posedge clk) disable iff (!arst_n) xfer |-> exp_avail)
    else report_mismatch($sformatf("egress beat %h matches no queued packet",
                                   $sampled(m_axis_tdata)));

  a_beat_value: assert property (@(posedge clk) disable iff (!arst_n)
    xfer && exp_avail |->
      m_axis_tdata == exp_data && m_axis_tkeep == exp_keep && m_axis_tlast == exp_last)
    else report_mismatch($sformatf("queue %0d beat %0d: got %h/%h/%b, expected %h/%h/%b",
                                   $sampled(cur_q), $sampled(beat_idx),
                                   $sampled(m_axis_tdata), $sampled(m_axis_tkeep),
                                   $sampled(m_axis_tlast), $sampled(exp_data),
                                   $sampled(exp_keep), $sampled(exp_last)));

  a_rr_order: assert property (@(posedge clk) disable iff (!arst_n) xfer && !in_pkt |-> rr_ok)
    else report_mismatch($sformatf("packet from queue %0d breaks round-robin order",
                                   $sampled(cur_q)));

  a_reg_ack: assert property (@(posedge clk) disable iff (!arst_n) reg_rd |=> reg_ack)
    else report_mismatch("register ack missing one cycle after the read");

  a_reg_data: assert property (@(posedge clk) disable iff (!arst_n)
    reg_ack |-> reg_data == exp_reg)
    else report_mismatch($sformatf("register read %0d, expected %0d",
                                   $sampled(reg_data), $sampled(exp_reg)));

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Header carries hdr_qid, then nbeats payload beats
  task automatic send_packet(input int hdr_qid, input int nbeats, input keep_t last_keep);
    int   q;
    int   i;
    logic accept;
    q = hdr_qid % NQ;
    @(posedge clk);
    accept = (hdr_qid < NQ) && (nbeats >= 1) && (nbeats <= MAXB) && (waiting(q) < DEPTH);
    if (accept) begin
      seq_m[q][wr_ptr[q] % RING]  = pkt_seq;
      len_m[q][wr_ptr[q] % RING]  = nbeats;
      keep_m[q][wr_ptr[q] % RING] = last_keep;
      wr_ptr[q]   = wr_ptr[q] + 1;
      sent_cnt[q] = sent_cnt[q] + 1;
    end else begin
      exp_drops = exp_drops + 1;
    end
    s_axis_tdata  <= {32'h0, 32'(hdr_qid)};
    s_axis_tkeep  <= '1;
    s_axis_tvalid <= 1'b1;
    s_axis_tlast  <= nbeats == 0;
    for (i = 0; i < nbeats; i++) begin
      @(posedge clk);
      s_axis_tdata <= beat_data(q, pkt_seq, i);
      s_axis_tkeep <= (i == nbeats - 1) ? last_keep : '1;
      s_axis_tlast <= i == nbeats - 1;
    end
    @(posedge clk);
    s_axis_tvalid <= 1'b0;
    s_axis_tlast  <= 1'b0;
    pkt_seq = pkt_seq + 1;
  endtask

  task automatic expect_start(input int q);
    rr_exp[rr_wr % RR_LEN] = q;
    rr_wr = rr_wr + 1;
  endtask

  // Packet at egress first, then the rule over what waits in the queues
  task automatic plan_rr_order();
    int pend [NQ];
    int last;
    int left;
    int q;
    int k;
    left = 0;
    for (q = 0; q < NQ; q++) begin
      pend[q] = waiting(q);
      left    = left + pend[q];
    end
    last = serving_q;
    expect_start(last);
    while (left > 0) begin
      for (k = 1; k <= NQ; k++) begin
        q = (last + k) % NQ;
        if (pend[q] > 0) begin
          break;
        end
      end
      expect_start(q);
      pend[q] = pend[q] - 1;
      left    = left - 1;
      last    = q;
    end
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (!drained()) begin
      @(posedge clk);
      n++;
      if (n > max_cycles) begin
        abort_run("Timed out waiting for all queued packets to leave egress");
      end
    end
  endtask

  task automatic wait_serving(input int max_cycles);
    int n;
    n = 0;
    while (!serving) begin
      @(posedge clk);
      n++;
      if (n > max_cycles) begin
        abort_run("Timed out waiting for a beat to show up at egress");
      end
    end
  endtask

  task automatic wait_room(input int q, input int max_cycles);
    int n;
    n = 0;
    while (sent_cnt[q] - done_cnt[q] >= DEPTH - 1) begin
      @(posedge clk);
      n++;
      if (n > max_cycles) begin
        abort_run("Timed out waiting for room in a queue");
      end
    end
  endtask

  task automatic read_reg(input int addr);
    int n;
    @(posedge clk);
    reg_rd   <= 1'b1;
    reg_addr <= reg_addr_t'(addr);
    exp_reg  <= cnt_t'(expected_reg(addr));
    @(posedge clk);
    reg_rd <= 1'b0;
    n = 0;
    while (!reg_ack) begin
      @(posedge clk);
      n++;
      if (n > 4) begin
        abort_run("Timed out waiting for the register ack");
      end
    end
  endtask

  initial begin
    int    i;
    int    hq;
    int    nb;
    keep_t kp;
    void'($urandom(32'ha356_f9c3));
    for (i = 0; i < NQ; i++) begin
      wr_ptr[i]   = 0;
      sent_cnt[i] = 0;
    end
    exp_drops     = 0;
    pkt_seq       = 0;
    rr_wr         = 0;
    exp_reg       = '0;
    rand_busy     = 1'b0;
    arst_n        = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    reg_rd        = 1'b0;
    reg_addr      = '0;
    repeat (10) @(posedge clk);
    arst_n        <= 1'b1;
    m_axis_tready <= 1'b1;

    // Pass-through with a partial last beat
    send_packet(0, 3, 8'h0F);
    wait_drained(200);

    // FIFO order within one queue
    send_packet(1, 2, 8'h01);
    send_packet(1, 5, 8'h3F);
    send_packet(1, 1, 8'hFF);
    send_packet(1, 8, 8'h7F);
    wait_drained(500);

    // Round-robin over queues 0, 1 and 3 filled behind a stall
    @(posedge clk);
    m_axis_tready <= 1'b0;
    for (i = 0; i < 2; i++) begin
      send_packet(0, 2, 8'hFF);
      idle(6);
      send_packet(1, 3, 8'h03);
      idle(6);
      send_packet(3, 1, 8'h0F);
      idle(6);
    end
    wait_serving(100);
    plan_rr_order();
    @(posedge clk);
    m_axis_tready <= 1'b1;
    wait_drained(1000);

    // Drops, egress stalled so queue 2 fills up
    @(posedge clk);
    m_axis_tready <= 1'b0;
    send_packet(5, 2, 8'hFF);
    idle(6);
    send_packet(0, 9, 8'hFF);
    idle(6);
    send_packet(1, 0, 8'hFF);
    idle(6);
    for (i = 0; i < DEPTH + 2; i++) begin
      send_packet(2, 1, 8'h01);                // Last one finds four waiting
      idle(6);
    end
    read_reg(NQ);
    @(posedge clk);
    m_axis_tready <= 1'b1;
    wait_drained(1000);

    // Random packets under random back-pressure
    rand_busy = 1'b1;
    fork
      begin
        for (i = 0; i < N_RAND; i++) begin
          hq = $urandom % (NQ + 1);
          if (hq == NQ) begin
            hq = NQ + $urandom % 4;            // Out of range id
          end
          nb = $urandom % (MAXB + 2);
          kp = keep_t'($urandom % 255 + 1);
          if (hq < NQ) begin
            wait_room(hq, 2000);
          end
          send_packet(hq, nb, kp);
          idle($urandom % 4);
        end
        wait_drained(4000);
        rand_busy = 1'b0;
      end
      begin
        while (rand_busy) begin
          @(posedge clk);
          m_axis_tready <= 1'($urandom % 2);
        end
      end
    join
    @(posedge clk);
    m_axis_tready <= 1'b1;
    for (i = 0; i < 8; i++) begin
      read_reg(i);
    end
    idle(2);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/packet_queue_manager.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pqm_config.svh"

module packet_queue_manager (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  wire pqm_pkg::data_t      s_axis_tdata_i,
  input  wire pqm_pkg::keep_t      s_axis_tkeep_i,
  input  wire logic                s_axis_tvalid_i,
  input  wire logic                s_axis_tlast_i,
  output logic                     s_axis_tready_o,
  output pqm_pkg::data_t           m_axis_tdata_o,
  output pqm_pkg::keep_t           m_axis_tkeep_o,
  output logic                     m_axis_tvalid_o,
  input  wire logic                m_axis_tready_i,
  output logic                     m_axis_tlast_o,
  input  wire logic                reg_rd_i,
  input  wire pqm_pkg::reg_addr_t  reg_addr_i,
  output logic                     reg_ack_o,
  output pqm_pkg::cnt_t            reg_data_o
);

  import pqm_pkg::*;

  localparam int unsigned BUF_DEPTH = `PQM_NUM_QUEUES * `PQM_QUEUE_DEPTH * `PQM_MAX_BEATS;

  // Ingress side
  qid_t      lookup_qid;
  logic      queue_full;
  slot_t     tail_slot;
  logic      buf_wr;
  buf_addr_t buf_wr_addr;
  beat_t     buf_wr_beat;
  logic      enq;
  qid_t      enq_qid;
  beats_t    enq_beats;
  logic      drop;

  // Scheduling and egress side
  logic [`PQM_NUM_QUEUES-1:0] nonempty;
  logic      pop;
  qid_t      pop_qid;
  logic      desc_valid;
  qid_t      desc_qid;
  slot_t     desc_slot;
  beats_t    desc_beats;
  logic      buf_rd;
  buf_addr_t buf_rd_addr;
  beat_t     buf_rd_beat;
  logic      tx_done;
  qid_t      tx_done_qid;

  rx_handler i_rx_handler (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tkeep_i  (s_axis_tkeep_i),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tready_o (s_axis_tready_o),
    .lookup_qid_o    (lookup_qid),
    .queue_full_i    (queue_full),
    .tail_slot_i     (tail_slot),
    .buf_wr_o        (buf_wr),
    .buf_addr_o      (buf_wr_addr),
    .buf_beat_o      (buf_wr_beat),
    .enq_o           (enq),
    .enq_qid_o       (enq_qid),
    .enq_beats_o     (enq_beats),
    .drop_o          (drop)
  );

  simple_dp_ram #(
    .entry_t (beat_t),
    .DEPTH   (BUF_DEPTH)
  ) i_packet_buffer (
    .clk_i     (clk_i),
    .wr_en_i   (buf_wr),
    .wr_addr_i (buf_wr_addr),
    .wr_data_i (buf_wr_beat),
    .rd_en_i   (buf_rd),
    .rd_addr_i (buf_rd_addr),
    .rd_data_o (buf_rd_beat)
  );

  descriptor_queues i_descriptor_queues (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .lookup_qid_i (lookup_qid),
    .queue_full_o (queue_full),
    .tail_slot_o  (tail_slot),
    .enq_i        (enq),
    .enq_qid_i    (enq_qid),
    .enq_beats_i  (enq_beats),
    .nonempty_o   (nonempty),
    .pop_i        (pop),
    .pop_qid_i    (pop_qid),
    .desc_valid_o (desc_valid),
    .desc_qid_o   (desc_qid),
    .desc_slot_o  (desc_slot),
    .desc_beats_o (desc_beats)
  );

  rr_scheduler i_rr_scheduler (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .nonempty_i (nonempty),
    .pop_o      (pop),
    .pop_qid_o  (pop_qid),
    .tx_done_i  (tx_done)
  );

  tx_handler i_tx_handler (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .desc_valid_i    (desc_valid),
    .desc_qid_i      (desc_qid),
    .desc_slot_i     (desc_slot),
    .desc_beats_i    (desc_beats),
    .buf_rd_o        (buf_rd),
    .buf_addr_o      (buf_rd_addr),
    .buf_beat_i      (buf_rd_beat),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tready_i (m_axis_tready_i),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .done_o          (tx_done),
    .done_qid_o      (tx_done_qid)
  );

  packet_counter i_packet_counter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .tx_done_i  (tx_done),
    .tx_qid_i   (tx_done_qid),
    .drop_i     (drop),
    .reg_rd_i   (reg_rd_i),
    .reg_addr_i (reg_addr_i),
    .reg_ack_o  (reg_ack_o),
    .reg_data_o (reg_data_o)
  );

endmodule

`default_nettype wire

/* hdl/packet_counter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pqm_config.svh"

module packet_counter (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  wire logic                tx_done_i,
  input  wire pqm_pkg::qid_t       tx_qid_i,
  input  wire logic                drop_i,
  input  wire logic                reg_rd_i,
  input  wire pqm_pkg::reg_addr_t  reg_addr_i,
  output logic                     reg_ack_o,
  output pqm_pkg::cnt_t            reg_data_o
);

  import pqm_pkg::*;

  localparam int unsigned NQ = `PQM_NUM_QUEUES;

  cnt_t tx_cnt_q [NQ];
  cnt_t drop_cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int q = 0; q < NQ; q++) begin
        tx_cnt_q[q] <= '0;
      end
      drop_cnt_q <= '0;
      reg_ack_o  <= 1'b0;
      reg_data_o <= '0;
    end else begin
      if (tx_done_i && (tx_cnt_q[tx_qid_i] != '1)) begin
        tx_cnt_q[tx_qid_i] <= tx_cnt_q[tx_qid_i] + 1'b1;     // Saturates
      end
      if (drop_i && (drop_cnt_q != '1)) begin
        drop_cnt_q <= drop_cnt_q + 1'b1;
      end
      reg_ack_o <= reg_rd_i;
      if (reg_rd_i) begin
        if (reg_addr_i < NQ) begin
          reg_data_o <= tx_cnt_q[qid_t'(reg_addr_i)];
        end else if (reg_addr_i == NQ) begin
          reg_data_o <= drop_cnt_q;
        end else begin
          reg_data_o <= '0;                                    // Unmapped
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/tx_handler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pqm_config.svh"

module tx_handler (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              desc_valid_i,
  input  wire pqm_pkg::qid_t     desc_qid_i,
  input  wire pqm_pkg::slot_t    desc_slot_i,
  input  wire pqm_pkg::beats_t   desc_beats_i,
  output logic                   buf_rd_o,
  output pqm_pkg::buf_addr_t     buf_addr_o,
  input  wire pqm_pkg::beat_t    buf_beat_i,
  output pqm_pkg::data_t         m_axis_tdata_o,
  output pqm_pkg::keep_t         m_axis_tkeep_o,
  output logic                   m_axis_tvalid_o,
  input  wire logic              m_axis_tready_i,
  output logic                   m_axis_tlast_o,
  output logic                   done_o,
  output pqm_pkg::qid_t          done_qid_o
);

  import pqm_pkg::*;

  localparam int unsigned BEAT_W = $clog2(`PQM_MAX_BEATS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_SEND
  } state_e;

  state_e state_q;
  beats_t idx_q;      // Beat being sent
  beats_t beats_q;
  qid_t   qid_q;
  slot_t  slot_q;
  logic   xfer;

  assign buf_rd_o   = state_q == S_READ;
  assign buf_addr_o = {qid_q, slot_q, idx_q[BEAT_W-1:0]};

  // RAM output holds between reads, so the beat stays stable under stall
  assign m_axis_tdata_o  = buf_beat_i.data;
  assign m_axis_tkeep_o  = buf_beat_i.keep;
  assign m_axis_tvalid_o = state_q == S_SEND;
  assign m_axis_tlast_o  = m_axis_tvalid_o && (idx_q == beats_q - 1'b1);

  assign xfer       = m_axis_tvalid_o && m_axis_tready_i;
  assign done_o     = xfer && m_axis_tlast_o;
  assign done_qid_o = qid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (desc_valid_i) begin
            idx_q   <= '0;
            state_q <= S_READ;
          end
        end
        S_READ: state_q <= S_SEND;
        default: begin
          if (xfer) begin
            idx_q   <= idx_q + 1'b1;
            state_q <= m_axis_tlast_o ? S_IDLE : S_READ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_valid_i && (state_q == S_IDLE)) begin
      qid_q   <= desc_qid_i;
      slot_q  <= desc_slot_i;
      beats_q <= desc_beats_i;
    end
  end

  a_stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axis_tvalid_o && !m_axis_tready_i |=>
      m_axis_tvalid_o && $stable(m_axis_tdata_o) && $stable(m_axis_tkeep_o))
    else $error("Egress beat changed while stalled");

endmodule

`default_nettype wire

/* hdl/rr_scheduler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pqm_config.svh"

module rr_scheduler (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic [`PQM_NUM_QUEUES-1:0]  nonempty_i,
  output logic                             pop_o,
  output pqm_pkg::qid_t                    pop_qid_o,
  input  wire logic                        tx_done_i
);

  import pqm_pkg::*;

  localparam int unsigned NQ = `PQM_NUM_QUEUES;

  qid_t last_q;       // Last queue served
  logic busy_q;       // Packet under transmission
  logic found;

  // First non-empty queue after the last one, wrapping around
  always_comb begin
    pop_qid_o = last_q;
    found     = 1'b0;
    for (int i = 1; i <= NQ; i++) begin
      if (!found && nonempty_i[qid_t'(last_q + i)]) begin
        pop_qid_o = qid_t'(last_q + i);
        found     = 1'b1;
      end
    end
  end

  assign pop_o = found && !busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= qid_t'(NQ - 1);                                 // Search begins at queue 0
      busy_q <= 1'b0;
    end else if (pop_o) begin
      last_q <= pop_qid_o;
      busy_q <= 1'b1;
    end else if (tx_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // Done only arrives for the packet in flight
  a_done_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tx_done_i |-> busy_q)
    else $error("Done strobe without a packet in flight");

endmodule

`default_nettype wire

/* hdl/descriptor_queues.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pqm_config.svh"

module descriptor_queues (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire pqm_pkg::qid_t               lookup_qid_i,
  output logic                             queue_full_o,
  output pqm_pkg::slot_t                   tail_slot_o,
  input  wire logic                        enq_i,
  input  wire pqm_pkg::qid_t               enq_qid_i,
  input  wire pqm_pkg::beats_t             enq_beats_i,
  output logic [`PQM_NUM_QUEUES-1:0]       nonempty_o,
  input  wire logic                        pop_i,
  input  wire pqm_pkg::qid_t               pop_qid_i,
  output logic                             desc_valid_o,
  output pqm_pkg::qid_t                    desc_qid_o,
  output pqm_pkg::slot_t                   desc_slot_o,
  output pqm_pkg::beats_t                  desc_beats_o
);

  import pqm_pkg::*;

  localparam int unsigned NQ    = `PQM_NUM_QUEUES;
  localparam int unsigned DEPTH = `PQM_QUEUE_DEPTH;

  typedef logic [$clog2(DEPTH+1)-1:0] count_t;

  slot_t   head_q  [NQ];
  slot_t   tail_q  [NQ];
  count_t  count_q [NQ];
  logic [NQ-1:0] enq_sel;
  logic [NQ-1:0] pop_sel;
  logic          enq_hit;

  assign enq_sel = enq_i ? (NQ'(1) << enq_qid_i) : '0;
  assign pop_sel = pop_i ? (NQ'(1) << pop_qid_i) : '0;

  // An enqueue in flight counts already, for back-to-back packets
  assign enq_hit      = enq_i && (enq_qid_i == lookup_qid_i);
  assign queue_full_o = count_q[lookup_qid_i] == (enq_hit ? DEPTH - 1 : DEPTH);
  assign tail_slot_o  = enq_hit ? slot_t'(tail_q[lookup_qid_i] + 1'b1) : tail_q[lookup_qid_i];

  always_comb begin
    for (int q = 0; q < NQ; q++) begin
      nonempty_o[q] = count_q[q] != '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int q = 0; q < NQ; q++) begin
        head_q[q]  <= '0;
        tail_q[q]  <= '0;
        count_q[q] <= '0;
      end
      desc_valid_o <= 1'b0;
    end else begin
      for (int q = 0; q < NQ; q++) begin
        if (enq_sel[q]) begin
          tail_q[q] <= tail_q[q] + 1'b1;
        end
        if (pop_sel[q]) begin
          head_q[q] <= head_q[q] + 1'b1;                      // Slot free again
        end
        count_q[q] <= count_q[q] + enq_sel[q] - pop_sel[q];
      end
      desc_valid_o <= pop_i;                                   // Lines up with RAM data
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_i) begin
      desc_qid_o  <= pop_qid_i;
      desc_slot_o <= head_q[pop_qid_i];
    end
  end

  simple_dp_ram #(
    .entry_t (beats_t),
    .DEPTH   (NQ * DEPTH)
  ) i_len_ram (
    .clk_i     (clk_i),
    .wr_en_i   (enq_i),
    .wr_addr_i ({enq_qid_i, tail_q[enq_qid_i]}),
    .wr_data_i (enq_beats_i),
    .rd_en_i   (pop_i),
    .rd_addr_i ({pop_qid_i, head_q[pop_qid_i]}),
    .rd_data_o (desc_beats_o)
  );

  a_no_enq_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    enq_i |-> count_q[enq_qid_i] != DEPTH)
    else $error("Enqueue into full queue %0d", enq_qid_i);

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> count_q[pop_qid_i] != '0)
    else $error("Pop from empty queue %0d", pop_qid_i);

endmodule

`default_nettype wire

/* hdl/rx_handler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pqm_config.svh"

module rx_handler (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire pqm_pkg::data_t    s_axis_tdata_i,
  input  wire pqm_pkg::keep_t    s_axis_tkeep_i,
  input  wire logic              s_axis_tvalid_i,
  input  wire logic              s_axis_tlast_i,
  output logic                   s_axis_tready_o,
  output pqm_pkg::qid_t          lookup_qid_o,
  input  wire logic              queue_full_i,
  input  wire pqm_pkg::slot_t    tail_slot_i,
  output logic                   buf_wr_o,
  output pqm_pkg::buf_addr_t     buf_addr_o,
  output pqm_pkg::beat_t         buf_beat_o,
  output logic                   enq_o,
  output pqm_pkg::qid_t          enq_qid_o,
  output pqm_pkg::beats_t        enq_beats_o,
  output logic                   drop_o
);

  import pqm_pkg::*;

  localparam int unsigned HDR_QID_W = 32;                      // Queue id field in the header
  localparam int unsigned BEAT_W    = $clog2(`PQM_MAX_BEATS);

  typedef enum logic [1:0] {
    S_HDR,
    S_PAY,
    S_DISC
  } state_e;

  state_e state_q;
  beats_t cnt_q;      // Payload beats written so far
  qid_t   qid_q;
  slot_t  slot_q;
  logic   hdr_ok;

  assign s_axis_tready_o = 1'b1;                               // Drops instead of stalling
  assign lookup_qid_o    = qid_t'(s_axis_tdata_i);
  assign hdr_ok          = (s_axis_tdata_i[HDR_QID_W-1:0] < `PQM_NUM_QUEUES) && !queue_full_i;

  assign buf_wr_o   = s_axis_tvalid_i && (state_q == S_PAY) && (cnt_q != `PQM_MAX_BEATS);
  assign buf_addr_o = {qid_q, slot_q, cnt_q[BEAT_W-1:0]};
  assign buf_beat_o = '{data: s_axis_tdata_i, keep: s_axis_tkeep_i};

  assign enq_qid_o   = qid_q;
  assign enq_beats_o = cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_HDR;
      cnt_q   <= '0;
      enq_o   <= 1'b0;
      drop_o  <= 1'b0;
    end else begin
      enq_o  <= 1'b0;
      drop_o <= 1'b0;
      if (s_axis_tvalid_i) begin
        case (state_q)
          S_HDR: begin
            cnt_q <= '0;
            if (s_axis_tlast_i) begin
              drop_o <= 1'b1;                                  // Header only
            end else begin
              state_q <= hdr_ok ? S_PAY : S_DISC;
            end
          end
          S_PAY: begin
            if (cnt_q == `PQM_MAX_BEATS) begin
              // One beat too many, the packet is lost
              drop_o  <= s_axis_tlast_i;
              state_q <= s_axis_tlast_i ? S_HDR : S_DISC;
            end else begin
              cnt_q <= cnt_q + 1'b1;
              if (s_axis_tlast_i) begin
                enq_o   <= 1'b1;
                state_q <= S_HDR;
              end
            end
          end
          default: begin
            if (s_axis_tlast_i) begin
              drop_o  <= 1'b1;
              state_q <= S_HDR;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s_axis_tvalid_i && (state_q == S_HDR)) begin
      qid_q  <= lookup_qid_o;
      slot_q <= tail_slot_i;                                   // Slot taken at header time
    end
  end

endmodule

`default_nettype wire

/* hdl/simple_dp_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module simple_dp_ram #(
  parameter type         entry_t = logic [7:0],
  parameter int unsigned DEPTH   = 16
) (
  input  wire logic                     clk_i,
  input  wire logic                     wr_en_i,
  input  wire logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  wire entry_t                   wr_data_i,
  input  wire logic                     rd_en_i,
  input  wire logic [$clog2(DEPTH)-1:0] rd_addr_i,
  output entry_t                        rd_data_o
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];  // Holds until the next read
    end
  end

endmodule

`default_nettype wire

/* hdl/pqm_pkg.sv */
`default_nettype none

`include "pqm_config.svh"

package pqm_pkg;

  typedef logic [`PQM_DATA_WIDTH-1:0]                 data_t;
  typedef logic [`PQM_DATA_WIDTH/8-1:0]               keep_t;
  typedef logic [$clog2(`PQM_NUM_QUEUES)-1:0]         qid_t;
  typedef logic [$clog2(`PQM_QUEUE_DEPTH)-1:0]        slot_t;
  typedef logic [$clog2(`PQM_MAX_BEATS+1)-1:0]        beats_t;   // Holds 1 to MAX_BEATS

  typedef struct packed {
    data_t data;
    keep_t keep;
  } beat_t;                                                     // Packet buffer entry

  // Queue, slot and beat index
  typedef logic [$clog2(`PQM_NUM_QUEUES*`PQM_QUEUE_DEPTH*`PQM_MAX_BEATS)-1:0] buf_addr_t;

  typedef logic [`PQM_CNT_WIDTH-1:0]                  cnt_t;
  typedef logic [$clog2(`PQM_NUM_QUEUES+1)-1:0]       reg_addr_t;  // Queue counts, then drops

endpackage

`default_nettype wire

/* hdl/pqm_config.svh */
`ifndef PQM_CONFIG_SVH
`define PQM_CONFIG_SVH

// Stream width in bits
`define PQM_DATA_WIDTH 64

// Queue count and packet slots per queue
`define PQM_NUM_QUEUES 4
`define PQM_QUEUE_DEPTH 4

// Longest accepted packet, payload beats only
`define PQM_MAX_BEATS 8

// Statistics counter width
`define PQM_CNT_WIDTH 16

`endif
